// ==== Bender.yml ====
package:
  name: esfa_benchmark

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/esfaPkg.sv
      - rtl/programStore.sv
      - rtl/esfaStore.sv
      - rtl/benchmarkRunner.sv
      - rtl/esfaBenchmark.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/esfaBenchmarkTb.sv

// ==== include/esfa_defs.svh ====
`ifndef ESFA_DEFS_SVH
`define ESFA_DEFS_SVH

////////////////////////////////////////////////////////////
// Store geometry
////////////////////////////////////////////////////////////

// Arrays addressable by handle
`define ESFA_HANDLES 4

// 8-bit entries in each array
`define ESFA_ENTRIES 16

////////////////////////////////////////////////////////////
// Program memory
////////////////////////////////////////////////////////////

// One 64-bit word per address
`define PROGRAM_DEPTH 64
`define PROGRAM_ADDR_WIDTH 6

`endif

// ==== rtl/benchmarkRunner.sv ====
`timescale 1ns/100ps

`include "esfa_defs.svh"

module benchmarkRunner (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           doRun,
  output logic [`PROGRAM_ADDR_WIDTH-1:0] readAddress,
  input  esfaPkg::programWordT           readWord,
  output esfaPkg::esfaRequestT           request,
  input  esfaPkg::esfaResultT            result,
  output logic                           isRunning,
  output logic                           wasSuccessful,
  output logic [`PROGRAM_ADDR_WIDTH-1:0] failStep
);

  import esfaPkg::*;

  runnerStateT state;

  // Set by a start, cleared once doRun drops
  logic       runHeld;
  logic       startRun;
  logic       stepMutating;
  esfaResultT stepExpected;
  logic       stepFailed;

  assign startRun = (state == stateIdle) && doRun && !runHeld;

  // Flag or value mismatch fails a query step
  assign stepFailed = !stepMutating && (result != stepExpected);

  // Request straight from the fetched word
  // no store access for the end word
  always_comb begin
    request.handle = readWord.handle;
    request.index  = readWord.newIndex;
    request.value  = readWord.newValue;
    request.op     = readWord.selector;
    request.valid  = (state == stateApply) && !readWord.endOfProgram;
  end

  // Expectations kept for the check cycle
  always_ff @(posedge clk) begin
    if (state == stateApply) begin
      stepMutating       <= readWord.isMutating;
      stepExpected.flag  <= readWord.expectedBool;
      stepExpected.value <= readWord.expectedValue;
    end
  end

  ////////////////////////////////////////////////////////////
  // Step sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      state         <= stateIdle;
      readAddress   <= '0;
      isRunning     <= 1'b0;
      wasSuccessful <= 1'b1;
      failStep      <= '0;
      runHeld       <= 1'b0;
    end else begin
      if (!doRun) begin
        runHeld <= 1'b0;
      end
      case (state)
        stateIdle: begin
          if (startRun) begin
            runHeld       <= 1'b1;
            state         <= stateFetch;
            readAddress   <= '0;
            isRunning     <= 1'b1;
            wasSuccessful <= 1'b1;
            failStep      <= '0;
          end
        end
        stateFetch: state <= stateApply;
        stateApply: begin
          if (readWord.endOfProgram) begin
            state     <= stateIdle;
            isRunning <= 1'b0;
          end else begin
            state <= stateCheck;
          end
        end
        stateCheck: begin
          if (stepFailed) begin
            state         <= stateIdle;
            isRunning     <= 1'b0;
            wasSuccessful <= 1'b0;
            failStep      <= readAddress;
          end else begin
            readAddress <= readAddress + 1'b1;
            state       <= stateFetch;
          end
        end
        default: state <= stateIdle;
      endcase
    end
  end

endmodule

// ==== rtl/esfaBenchmark.sv ====
`timescale 1ns/100ps

`include "esfa_defs.svh"

module esfaBenchmark (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           load,
  input  logic [`PROGRAM_ADDR_WIDTH-1:0] loadAddress,
  input  esfaPkg::programWordT           loadWord,
  input  logic                           doRun,
  output logic                           isRunning,
  output logic                           wasSuccessful,
  output logic [`PROGRAM_ADDR_WIDTH-1:0] failStep
);

  import esfaPkg::*;

  logic [`PROGRAM_ADDR_WIDTH-1:0] readAddress;
  programWordT                    readWord;
  esfaRequestT                    request;
  esfaResultT                     result;

  // Program words, loaded from outside while idle
  programStore programMemory (
    .clk        (clk),
    .load       (load),
    .loadAddress(loadAddress),
    .loadWord   (loadWord),
    .readAddress(readAddress),
    .readWord   (readWord)
  );

  esfaStore store (
    .clk    (clk),
    .reset  (reset),
    .request(request),
    .result (result)
  );

  // Fetch, apply, check per word
  benchmarkRunner runner (
    .clk          (clk),
    .reset        (reset),
    .doRun        (doRun),
    .readAddress  (readAddress),
    .readWord     (readWord),
    .request      (request),
    .result       (result),
    .isRunning    (isRunning),
    .wasSuccessful(wasSuccessful),
    .failStep     (failStep)
  );

endmodule

// ==== rtl/esfaPkg.sv ====
package esfaPkg;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Store operations, opWrite and opClear mutate
  typedef enum logic [7:0] {
    opWrite = 8'h00,
    opClear = 8'h01,
    opRead  = 8'h02,
    opFind  = 8'h03,
    opCount = 8'h04
  } esfaOpT;

  typedef enum logic [1:0] {
    stateIdle,
    stateFetch,
    stateApply,
    stateCheck
  } runnerStateT;

  ////////////////////////////////////////////////////////////
  // Bundles
  ////////////////////////////////////////////////////////////

  // One program word, flags in the low byte
  typedef struct packed {
    logic [15:0] spareHigh;
    logic [7:0]  expectedValue;
    esfaOpT      selector;
    logic [7:0]  newValue;
    logic [7:0]  newIndex;
    logic [7:0]  handle;
    logic [4:0]  spareLow;
    logic        endOfProgram;
    logic        expectedBool;
    logic        isMutating;
  } programWordT;

  typedef struct packed {
    logic [7:0] handle;
    logic [7:0] index;
    logic [7:0] value;
    esfaOpT     op;
    logic       valid;
  } esfaRequestT;

  typedef struct packed {
    logic       flag;
    logic [7:0] value;
  } esfaResultT;

endpackage

// ==== rtl/esfaStore.sv ====
`timescale 1ns/100ps

`include "esfa_defs.svh"

module esfaStore (
  input  logic                 clk,
  input  logic                 reset,
  input  esfaPkg::esfaRequestT request,
  output esfaPkg::esfaResultT  result
);

  import esfaPkg::*;

  localparam int HandleBits = $clog2(`ESFA_HANDLES);
  localparam int IndexBits  = $clog2(`ESFA_ENTRIES);
  localparam int CountBits  = $clog2(`ESFA_ENTRIES + 1);

  // One packed row of entries per handle
  logic [`ESFA_ENTRIES-1:0][7:0] entries [`ESFA_HANDLES];
  logic [CountBits-1:0]          counts  [`ESFA_HANDLES];

  logic [HandleBits-1:0]         selHandle;
  logic [IndexBits-1:0]          selIndex;
  logic [`ESFA_ENTRIES-1:0][7:0] handleRow;
  logic [7:0]                    oldEntry;
  logic                          entryWasSet;
  logic                          entryWillSet;
  logic                          findHit;
  logic [7:0]                    findIndex;

  // Higher handle and index bits are ignored
  assign selHandle = request.handle[HandleBits-1:0];
  assign selIndex  = request.index[IndexBits-1:0];

  assign handleRow = entries[selHandle];
  assign oldEntry  = handleRow[selIndex];

  // Zero/nonzero transition of the written entry
  assign entryWasSet  = (oldEntry != 8'd0);
  assign entryWillSet = (request.value != 8'd0);

  ////////////////////////////////////////////////////////////
  // Find
  ////////////////////////////////////////////////////////////

  // Scan from the top down so the lowest match wins
  always_comb begin
    findHit   = 1'b0;
    findIndex = 8'hFF;
    for (int i = `ESFA_ENTRIES - 1; i >= 0; i--) begin
      if (handleRow[i] == request.value) begin
        findHit   = 1'b1;
        findIndex = 8'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Mutations
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      for (int h = 0; h < `ESFA_HANDLES; h++) begin
        entries[h] <= '0;
        counts[h]  <= '0;
      end
    end else if (request.valid) begin
      case (request.op)
        opWrite: begin
          entries[selHandle][selIndex] <= request.value;
          // Count moves only on a zero/nonzero change
          if (!entryWasSet && entryWillSet) begin
            counts[selHandle] <= counts[selHandle] + 1'b1;
          end else if (entryWasSet && !entryWillSet) begin
            counts[selHandle] <= counts[selHandle] - 1'b1;
          end
        end
        opClear: begin
          entries[selHandle] <= '0;
          counts[selHandle]  <= '0;
        end
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Query result
  ////////////////////////////////////////////////////////////

  // Holds between queries, mutations leave it alone
  always_ff @(posedge clk) begin
    if (request.valid) begin
      case (request.op)
        opRead: begin
          result.flag  <= entryWasSet;
          result.value <= oldEntry;
        end
        opFind: begin
          result.flag  <= findHit;
          result.value <= findIndex;
        end
        opCount: begin
          result.flag  <= (counts[selHandle] != '0);
          result.value <= 8'(counts[selHandle]);
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// ==== rtl/programStore.sv ====
`timescale 1ns/100ps

`include "esfa_defs.svh"

module programStore (
  input  logic                           clk,
  input  logic                           load,
  input  logic [`PROGRAM_ADDR_WIDTH-1:0] loadAddress,
  input  esfaPkg::programWordT           loadWord,
  input  logic [`PROGRAM_ADDR_WIDTH-1:0] readAddress,
  output esfaPkg::programWordT           readWord
);

  import esfaPkg::*;

  ////////////////////////////////////////////////////////////
  // Word array
  ////////////////////////////////////////////////////////////

  // Contents come only from loading
  programWordT words [`PROGRAM_DEPTH];

  // Load port, used while the runner is idle
  always_ff @(posedge clk) begin
    if (load) begin
      words[loadAddress] <= loadWord;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////

  // Registered read
  // address in fetch, word visible in apply
  always_ff @(posedge clk) begin
    readWord <= words[readAddress];
  end

endmodule

// ==== sim.f ====
+incdir+include
rtl/esfaPkg.sv
rtl/programStore.sv
rtl/esfaStore.sv
rtl/benchmarkRunner.sv
rtl/esfaBenchmark.sv
tests/esfaBenchmarkTb.sv

// ==== tests/esfaBenchmarkTb.sv ====
`timescale 1ns/100ps

`include "esfa_defs.svh"

module esfaBenchmarkTb;

  import esfaPkg::*;

  localparam int AddrWidth = `PROGRAM_ADDR_WIDTH;

  // One test: a slice of the row table plus its expected outcome
  typedef struct packed {
    logic [7:0]           start;
    logic [7:0]           length;
    logic                 expSuccess;
    logic [AddrWidth-1:0] expFailStep;
    logic [7:0]           expCycles;
    logic [1:0]           runs;
  } testT;

  logic                 clk;
  logic                 reset;
  logic                 load;
  logic [AddrWidth-1:0] loadAddress;
  programWordT          loadWord;
  logic                 doRun;
  logic                 isRunning;
  logic                 wasSuccessful;
  logic [AddrWidth-1:0] failStep;

  programWordT rows [64];
  int          rowCount;
  testT        tests [8];
  string       testNames [8];
  int          testTotal;
  int          testCount;
  int          passCount;
  int          errorCount;
  int          cycleCount;
  int          cycleLimit;

  esfaBenchmark uut (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .loadAddress  (loadAddress),
    .loadWord     (loadWord),
    .doRun        (doRun),
    .isRunning    (isRunning),
    .wasSuccessful(wasSuccessful),
    .failStep     (failStep)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Word builders
  ////////////////////////////////////////////////////////////

  function automatic programWordT packWord(esfaOpT op, logic mutating, logic [7:0] handle,
                                           logic [7:0] index, logic [7:0] value,
                                           logic expBool, logic [7:0] expValue);
    programWordT w;
    w = '0;
    w.selector      = op;
    w.isMutating    = mutating;
    w.handle        = handle;
    w.newIndex      = index;
    w.newValue      = value;
    w.expectedBool  = expBool;
    w.expectedValue = expValue;
    return w;
  endfunction

  function automatic programWordT mutationWord(esfaOpT op, logic [7:0] handle,
                                               logic [7:0] index, logic [7:0] value);
    return packWord(op, 1'b1, handle, index, value, 1'b0, 8'h00);
  endfunction

  function automatic programWordT queryWord(esfaOpT op, logic [7:0] handle, logic [7:0] index,
                                            logic [7:0] value, logic expBool,
                                            logic [7:0] expValue);
    return packWord(op, 1'b0, handle, index, value, expBool, expValue);
  endfunction

  function automatic programWordT endWord();
    programWordT w;
    w = '0;
    w.endOfProgram = 1'b1;
    return w;
  endfunction

  task automatic addRow(input programWordT w);
    rows[rowCount] = w;
    rowCount++;
  endtask

  task automatic addTest(input string name, input int start, input logic expSuccess,
                         input int expFailStep, input int expCycles, input int runs);
    tests[testTotal].start       = 8'(start);
    tests[testTotal].length      = 8'(rowCount - start);
    tests[testTotal].expSuccess  = expSuccess;
    tests[testTotal].expFailStep = AddrWidth'(expFailStep);
    tests[testTotal].expCycles   = 8'(expCycles);
    tests[testTotal].runs        = 2'(runs);
    testNames[testTotal]         = name;
    testTotal++;
  endtask

  ////////////////////////////////////////////////////////////
  // Program table
  ////////////////////////////////////////////////////////////

  task automatic buildTable();
    int s;
    // Writes then reads, one unwritten index
    s = rowCount;
    addRow(mutationWord(opClear, 0, 0, 0));
    addRow(mutationWord(opWrite, 0, 3, 8'h5A));
    addRow(mutationWord(opWrite, 0, 7, 8'h01));
    addRow(queryWord(opRead, 0, 3, 0, 1'b1, 8'h5A));
    addRow(queryWord(opRead, 0, 7, 0, 1'b1, 8'h01));
    addRow(queryWord(opRead, 0, 9, 0, 1'b0, 8'h00));
    addRow(endWord());
    addTest("write/read", s, 1'b1, 0, 0, 1);
    // Count follows zero/nonzero changes only
    s = rowCount;
    addRow(mutationWord(opClear, 1, 0, 0));
    addRow(mutationWord(opWrite, 1, 0, 8'h11));
    addRow(mutationWord(opWrite, 1, 1, 8'h22));
    addRow(mutationWord(opWrite, 1, 2, 8'h33));
    addRow(queryWord(opCount, 1, 0, 0, 1'b1, 8'd3));
    addRow(mutationWord(opWrite, 1, 1, 8'h00));
    addRow(mutationWord(opWrite, 1, 5, 8'h00));
    addRow(queryWord(opCount, 1, 0, 0, 1'b1, 8'd2));
    addRow(mutationWord(opWrite, 1, 0, 8'h00));
    addRow(mutationWord(opWrite, 1, 2, 8'h00));
    addRow(queryWord(opCount, 1, 0, 0, 1'b0, 8'd0));
    addRow(endWord());
    addTest("count", s, 1'b1, 0, 0, 1);
    // Lowest duplicate, absent value, then clear
    s = rowCount;
    addRow(mutationWord(opClear, 2, 0, 0));
    addRow(mutationWord(opWrite, 2, 9, 8'h77));
    addRow(mutationWord(opWrite, 2, 4, 8'h77));
    addRow(mutationWord(opWrite, 2, 12, 8'h77));
    addRow(mutationWord(opWrite, 2, 2, 8'h10));
    addRow(queryWord(opFind, 2, 0, 8'h77, 1'b1, 8'd4));
    addRow(queryWord(opFind, 2, 0, 8'h10, 1'b1, 8'd2));
    addRow(queryWord(opFind, 2, 0, 8'h99, 1'b0, 8'hFF));
    addRow(mutationWord(opClear, 2, 0, 0));
    addRow(queryWord(opCount, 2, 0, 0, 1'b0, 8'd0));
    addRow(endWord());
    addTest("find", s, 1'b1, 0, 0, 1);
    // Third query has the wrong value
    s = rowCount;
    addRow(mutationWord(opClear, 3, 0, 0));
    addRow(mutationWord(opWrite, 3, 1, 8'h05));
    addRow(queryWord(opRead, 3, 1, 0, 1'b1, 8'h05));
    addRow(queryWord(opCount, 3, 0, 0, 1'b1, 8'd1));
    addRow(queryWord(opRead, 3, 1, 0, 1'b1, 8'h06));
    addRow(queryWord(opCount, 3, 0, 0, 1'b1, 8'd1));
    addRow(endWord());
    addTest("wrong value", s, 1'b0, 4, 0, 1);
    // Right value, wrong flag
    s = rowCount;
    addRow(mutationWord(opClear, 3, 0, 0));
    addRow(mutationWord(opWrite, 3, 2, 8'h08));
    addRow(queryWord(opRead, 3, 2, 0, 1'b0, 8'h08));
    addRow(endWord());
    addTest("wrong flag", s, 1'b0, 2, 0, 1);
    // Three words, 3N+2 = 11 cycles, run twice
    s = rowCount;
    addRow(mutationWord(opClear, 0, 0, 0));
    addRow(mutationWord(opWrite, 0, 0, 8'h2A));
    addRow(queryWord(opRead, 0, 0, 0, 1'b1, 8'h2A));
    addRow(endWord());
    addTest("timing/restart", s, 1'b1, 0, 11, 2);
    // Garbage expectations on a mutation, independent handles
    s = rowCount;
    addRow(mutationWord(opClear, 1, 0, 0));
    addRow(mutationWord(opClear, 2, 0, 0));
    addRow(packWord(opWrite, 1'b1, 1, 6, 8'hC3, 1'b1, 8'hEE));
    addRow(queryWord(opRead, 2, 6, 0, 1'b0, 8'h00));
    addRow(queryWord(opRead, 1, 6, 0, 1'b1, 8'hC3));
    addRow(queryWord(opCount, 2, 0, 0, 1'b0, 8'd0));
    addRow(endWord());
    addTest("mutation/handles", s, 1'b1, 0, 0, 1);
  endtask

  ////////////////////////////////////////////////////////////
  // Test runner
  ////////////////////////////////////////////////////////////

  task automatic runTest(input int t);
    testT tc;
    int   cycles;
    int   errorsBefore;
    tc = tests[t];
    errorsBefore = errorCount;
    for (int i = 0; i < int'(tc.length); i++) begin
      @(negedge clk);
      load        = 1'b1;
      loadAddress = AddrWidth'(i);
      loadWord    = rows[int'(tc.start) + i];
    end
    @(negedge clk);
    load = 1'b0;
    for (int r = 0; r < int'(tc.runs); r++) begin
      doRun = 1'b1;
      @(negedge clk);
      doRun = 1'b0;
      if (isRunning !== 1'b1) begin
        $display("Test %s: the run did not start after doRun", testNames[t]);
        errorCount++;
      end
      // Start must set wasSuccessful again
      if (wasSuccessful !== 1'b1) begin
        $display("FAIL t=%0t %s: wasSuccessful at start = %0b, expected 1",
                 $time, testNames[t], wasSuccessful);
        errorCount++;
      end
      cycles = 0;
      while (isRunning) begin
        cycles++;
        @(negedge clk);
      end
      if (wasSuccessful !== tc.expSuccess) begin
        $display("FAIL t=%0t %s: wasSuccessful = %0b, expected %0b",
                 $time, testNames[t], wasSuccessful, tc.expSuccess);
        errorCount++;
      end
      if (failStep !== tc.expFailStep) begin
        $display("FAIL t=%0t %s: failStep = %0d, expected %0d",
                 $time, testNames[t], failStep, tc.expFailStep);
        errorCount++;
      end
      if (tc.expCycles != 0 && cycles != int'(tc.expCycles)) begin
        $display("FAIL t=%0t %s: isRunning cycles = %0d, expected %0d",
                 $time, testNames[t], cycles, tc.expCycles);
        errorCount++;
      end
      @(negedge clk);
    end
    testCount++;
    if (errorCount == errorsBefore) begin
      passCount++;
      $display("Test %0d %s: ok", t + 1, testNames[t]);
    end else begin
      $display("Test %0d %s: %0d error(s)", t + 1, testNames[t], errorCount - errorsBefore);
    end
  endtask

  // Watchdog
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    clk         = 1'b0;
    reset       = 1'b0;
    load        = 1'b0;
    loadAddress = '0;
    loadWord    = '0;
    doRun       = 1'b0;
    rowCount    = 0;
    testTotal   = 0;
    testCount   = 0;
    passCount   = 0;
    errorCount  = 0;
    cycleCount  = 0;
    buildTable();
    // Load, run and slack per run, plus reset
    cycleLimit = 10;
    for (int t = 0; t < testTotal; t++) begin
      cycleLimit += int'(tests[t].runs) * (int'(tests[t].length) * 4 + 20);
    end
    repeat (2) @(negedge clk);
    reset = 1'b1;
    for (int t = 0; t < testTotal; t++) begin
      runTest(t);
    end
    $display("Tests %0d, passed %0d, failed %0d, errors %0d",
             testCount, passCount, testCount - passCount, errorCount);
    if (errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
